// ==== compile.f ====
+incdir+testbench
src/risk_pkg.sv
src/order_dispatch.sv
src/risk_lane.sv
src/decision_collector.sv
src/risk_gate_top.sv
testbench/tb_risk_gate.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the risk gate testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_risk_gate -f compile.f -o tb_risk_gate

# a failing run still leaves its log for the search below
./obj_dir/tb_risk_gate > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
  echo "simulation PASSED"
else
  echo "simulation FAILED, see sim.log"
  exit 1
fi

// ==== testbench/risk_model.svh ====
`ifndef RISK_MODEL_SVH
`define RISK_MODEL_SVH

// per client limit state, plain ints so sums never wrap
int lim_max [32];
int lim_acc [32];

// expected decision words, one queue per client
logic [31:0] exp_q [32][$];

function automatic void reset_model();
  for (int c = 0; c < 32; c++) begin
    lim_max[c] = 0;   // tables come up cleared
    lim_acc[c] = 0;
    exp_q[c].delete();
  end
endfunction

// applies one acked command to the model
function automatic void apply_command(input cmd_op_t op, input int client, input int amount);
  logic [31:0] word;
  bit          ok;
  case (op)
    OP_ORDER: begin
      ok = (lim_acc[client] + amount) < lim_max[client];   // strictly below
      if (ok) lim_acc[client] = lim_acc[client] + amount;
      word        = 32'h4000_0000;       // valid bit
      word[31]    = ok;
      word[28:24] = client[4:0];
      word[15:0]  = lim_acc[client][15:0];
      exp_q[client].push_back(word);
    end
    OP_SET_MAX: lim_max[client] = amount;
    OP_CANCEL: begin
      // floor at zero
      if (amount >= lim_acc[client]) lim_acc[client] = 0;
      else                          lim_acc[client] = lim_acc[client] - amount;
    end
    default: ;                           // code 3 write is ignored
  endcase
endfunction

// decisions still owed by the DUT
function automatic int pending_decisions();
  int total;
  total = 0;
  for (int c = 0; c < 32; c++) begin
    total += exp_q[c].size();
  end
  return total;
endfunction

`endif

// ==== testbench/tb_risk_gate.sv ====
`timescale 1ns/1ns

module tb_risk_gate import risk_pkg::*; ();

  localparam int NUM_LANES  = 4;
  localparam int FIFO_DEPTH = 8;
  localparam int TIMEOUT    = 100;   // cycles per bus wait

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  cmd_op_t     wb_adr;
  logic [31:0] wb_dat_w;
  logic        wb_ack;
  logic [31:0] wb_dat_r;

  `include "risk_model.svh"

  risk_gate_top #(.NUM_LANES(NUM_LANES), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r)
  );

  always #4 clk = ~clk;   // 8 ns period

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] want, input logic [31:0] got);
    if (want !== got) begin
      $display("Error %s: expected %h, actual %h", name, want, got);
      stop_run("value mismatch");
    end
  endtask

  // called on a falling edge, returns on the falling edge that sees ack
  task automatic wb_write(input cmd_op_t op, input int client, input int amount,
                          input bit may_stall, output bit acked);
    bit got;
    got      = 1'b0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = op;
    wb_dat_w = {11'd0, client[4:0], amount[15:0]};
    for (int n = 0; n < TIMEOUT && !got; n++) begin
      @(negedge clk);
      got = wb_ack;
    end
    wb_cyc = 1'b0;   // also ends a stalled cycle with no transfer
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    acked  = got;
    if (got) apply_command(op, client, amount);
    else if (!may_stall) stop_run("timeout waiting for write ack");
  endtask

  task automatic wb_read(output logic [31:0] data);
    bit got;
    got      = 1'b0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b0;
    wb_adr   = OP_DECISION;
    wb_dat_w = '0;
    for (int n = 0; n < TIMEOUT && !got; n++) begin
      @(negedge clk);
      got = wb_ack;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    data   = wb_dat_r;   // registered with ack
    if (!got) stop_run("timeout waiting for read ack");
  endtask

  // valid word against the head of its client's queue
  task automatic match_decision(input string name, input logic [31:0] word);
    int          client;
    logic [31:0] want;
    client = int'(word[28:24]);
    if (exp_q[client].size() == 0) begin
      stop_run($sformatf("decision for client %0d with none expected", client));
    end else begin
      want = exp_q[client].pop_front();
      check(name, want, word);
    end
  endtask

  // reads until the model owes nothing, empty reads just retry
  task automatic drain_decisions(input string name);
    logic [31:0] word;
    int          tries;
    tries = 0;
    while (pending_decisions() > 0 && tries < TIMEOUT) begin
      wb_read(word);
      tries++;
      if (word[30]) begin
        match_decision(name, word);
        tries = 0;
      end
    end
    if (pending_decisions() > 0) stop_run("expected decisions never arrived");
    wb_read(word);   // one decision per order, nothing extra left behind
    check($sformatf("%s trailing read", name), 32'h0, word);
  endtask

  initial begin
    logic [31:0] word;
    int          acked_n;
    int          r;
    int          client;
    bit          acked;
    clk      = 1'b0;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = OP_ORDER;
    wb_dat_w = '0;
    void'($urandom(90));
    reset_model();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // untouched client, max is 0
    wb_write(OP_ORDER, 5, 10, 1'b0, acked);
    drain_decisions("reset state");

    // boundary around the max
    wb_write(OP_SET_MAX, 9, 100, 1'b0, acked);
    wb_write(OP_ORDER, 9, 60, 1'b0, acked);      // 60
    wb_write(OP_ORDER, 9, 40, 1'b0, acked);      // would hit 100
    wb_write(OP_ORDER, 9, 39, 1'b0, acked);      // 99, last in
    wb_write(OP_ORDER, 9, 1, 1'b0, acked);       // 100 again
    wb_write(OP_SET_MAX, 20, 65535, 1'b0, acked);
    wb_write(OP_ORDER, 20, 65534, 1'b0, acked);  // top of the range
    wb_write(OP_ORDER, 20, 1, 1'b0, acked);
    drain_decisions("limit rule");

    // cancels
    wb_write(OP_CANCEL, 9, 50, 1'b0, acked);     // 99 down to 49
    wb_write(OP_ORDER, 9, 1, 1'b0, acked);
    wb_write(OP_CANCEL, 9, 1000, 1'b0, acked);   // saturates
    wb_write(OP_ORDER, 9, 7, 1'b0, acked);
    drain_decisions("cancel rule");

    // random mix, reads kept frequent enough that writes never block
    for (int i = 0; i < 400; i++) begin
      r      = $urandom % 10;
      client = $urandom % 32;
      if (r >= 8 || pending_decisions() >= FIFO_DEPTH) begin
        wb_read(word);
        if (word[30]) match_decision("random mix", word);
      end else if (r < 5) begin
        wb_write(OP_ORDER, client, $urandom % 4096, 1'b0, acked);
      end else if (r < 7) begin
        wb_write(OP_SET_MAX, client, $urandom % 65536, 1'b0, acked);
      end else begin
        wb_write(OP_CANCEL, client, $urandom % 8192, 1'b0, acked);
      end
    end
    drain_decisions("random mix");

    // fill fifo and every lane, next order must stall
    acked_n = 0;
    for (int i = 0; i < FIFO_DEPTH + NUM_LANES + 4; i++) begin
      wb_write(OP_ORDER, i % 32, $urandom % 256, 1'b1, acked);
      if (!acked) break;
      acked_n++;
    end
    check("back-pressure acked", FIFO_DEPTH + NUM_LANES, acked_n);
    drain_decisions("back-pressure");

    // code 3 write does nothing, then nothing is pending
    wb_write(OP_DECISION, 3, 5, 1'b0, acked);
    wb_read(word);
    check("empty read", 32'h0, word);

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== src/risk_gate_top.sv ====
`timescale 1ns/1ns

module risk_gate_top import risk_pkg::*; #(
  parameter int NUM_LANES  = 4,   // 2, 4 or 8
  parameter int FIFO_DEPTH = 8    // power of two
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  cmd_op_t     wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic        wb_ack,
  output logic [31:0] wb_dat_r
);

  // dispatcher -> lanes, op/client/amount shared by all lanes
  logic       [NUM_LANES-1:0] cmd_valid;
  logic       [NUM_LANES-1:0] cmd_ready;
  cmd_op_t                    cmd_op;
  client_id_t                 cmd_client;
  amount_t                    cmd_amount;

  // lanes -> collector
  logic       [NUM_LANES-1:0] dec_valid;
  logic       [NUM_LANES-1:0] dec_ready;
  logic       [NUM_LANES-1:0] dec_accept;
  client_id_t [NUM_LANES-1:0] dec_client;
  amount_t    [NUM_LANES-1:0] dec_acc;

  // collector -> dispatcher
  logic      fifo_empty;
  logic      fifo_pop;
  decision_t fifo_head;

  order_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_ack     (wb_ack),
    .wb_dat_r   (wb_dat_r),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_op     (cmd_op),
    .cmd_client (cmd_client),
    .cmd_amount (cmd_amount),
    .fifo_empty (fifo_empty),
    .fifo_head  (fifo_head),
    .fifo_pop   (fifo_pop)
  );

  // one lane per shard of clients
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    risk_lane #(.NUM_LANES(NUM_LANES)) u_lane (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid[g]),
      .cmd_ready  (cmd_ready[g]),
      .cmd_op     (cmd_op),
      .cmd_client (cmd_client),
      .cmd_amount (cmd_amount),
      .dec_valid  (dec_valid[g]),
      .dec_ready  (dec_ready[g]),
      .dec_accept (dec_accept[g]),
      .dec_client (dec_client[g]),
      .dec_acc    (dec_acc[g])
    );
  end

  decision_collector #(.NUM_LANES(NUM_LANES), .FIFO_DEPTH(FIFO_DEPTH)) u_collect (
    .clk        (clk),
    .rst_n      (rst_n),
    .dec_valid  (dec_valid),
    .dec_ready  (dec_ready),
    .dec_accept (dec_accept),
    .dec_client (dec_client),
    .dec_acc    (dec_acc),
    .fifo_pop   (fifo_pop),
    .fifo_empty (fifo_empty),
    .fifo_head  (fifo_head)
  );

endmodule

// ==== src/decision_collector.sv ====
`timescale 1ns/1ns

module decision_collector import risk_pkg::*; #(
  parameter int NUM_LANES  = 4,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // lane decisions
  input  logic       [NUM_LANES-1:0] dec_valid,
  output logic       [NUM_LANES-1:0] dec_ready,
  input  logic       [NUM_LANES-1:0] dec_accept,
  input  client_id_t [NUM_LANES-1:0] dec_client,
  input  amount_t    [NUM_LANES-1:0] dec_acc,
  // result fifo read side
  input  logic                       fifo_pop,
  output logic                       fifo_empty,
  output decision_t                  fifo_head
);

  localparam int LANE_BITS = $clog2(NUM_LANES);
  localparam int PTR_BITS  = $clog2(FIFO_DEPTH);

  typedef logic [LANE_BITS-1:0] lane_idx_t;
  typedef logic [PTR_BITS-1:0]  ptr_t;

  lane_idx_t rr_ptr;        // first lane to look at
  lane_idx_t grant_idx;
  logic      grant_found;
  logic      fifo_full;
  logic      push;
  logic      pop;
  decision_t push_word;

  decision_t       mem [FIFO_DEPTH];
  ptr_t            wr_ptr;
  ptr_t            rd_ptr;
  logic [PTR_BITS:0] count;   // 0..FIFO_DEPTH

  assign fifo_full  = (count == (PTR_BITS+1)'(FIFO_DEPTH));
  assign fifo_empty = (count == '0);
  assign fifo_head  = mem[rd_ptr];

  // round robin search starting at rr_ptr, wraps on lane_idx_t width
  always_comb begin
    lane_idx_t cand;
    grant_found = 1'b0;
    grant_idx   = rr_ptr;
    for (int i = 0; i < NUM_LANES; i++) begin
      cand = rr_ptr + lane_idx_t'(i);
      if (!grant_found && dec_valid[cand]) begin
        grant_found = 1'b1;
        grant_idx   = cand;
      end
    end
  end

  assign push = grant_found & ~fifo_full;   // full fifo stalls every lane
  assign pop  = fifo_pop & ~fifo_empty;
  assign dec_ready = push ? ({{(NUM_LANES-1){1'b0}}, 1'b1} << grant_idx) : '0;

  // pack the granted decision
  always_comb begin
    push_word = '0;
    push_word[DEC_ACCEPT_BIT] = dec_accept[grant_idx];
    push_word[DEC_VALID_BIT]  = 1'b1;                 // read path returns it as is
    push_word[DEC_CLIENT_LSB +: $bits(client_id_t)] = dec_client[grant_idx];
    push_word[DEC_ACC_LSB +: $bits(amount_t)]       = dec_acc[grant_idx];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_ptr <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        rr_ptr <= grant_idx + 1'b1;   // skip past the winner, no starvation
        wr_ptr <= wr_ptr + 1'b1;      // power of two depth, wraps
      end
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                    // both or neither
      endcase
    end
  end

  // storage, readable the cycle after the grant
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_word;
  end

endmodule

// ==== src/risk_lane.sv ====
`timescale 1ns/1ns

module risk_lane import risk_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  // command in
  input  logic       cmd_valid,
  output logic       cmd_ready,
  input  cmd_op_t    cmd_op,
  input  client_id_t cmd_client,
  input  amount_t    cmd_amount,
  // decision out
  output logic       dec_valid,
  input  logic       dec_ready,
  output logic       dec_accept,
  output client_id_t dec_client,
  output amount_t    dec_acc
);

  localparam int LANE_BITS = $clog2(NUM_LANES);
  localparam int ENTRIES   = NUM_CLIENTS / NUM_LANES;   // clients in this shard
  localparam int IDX_BITS  = $clog2(ENTRIES);

  typedef logic [IDX_BITS-1:0] idx_t;

  lane_state_t state;

  // latched command
  cmd_op_t    req_op;
  client_id_t req_client;
  amount_t    req_amount;
  idx_t       req_idx;

  // limit table for the shard
  amount_t max_tab [ENTRIES];
  amount_t acc_tab [ENTRIES];

  // entry read in LANE_READ
  amount_t cur_max;
  amount_t cur_acc;

  // update results
  exposure_t sum;
  logic      accept;
  amount_t   new_max;
  amount_t   new_acc;

  assign cmd_ready  = (state == LANE_IDLE);
  assign dec_valid  = (state == LANE_POST);
  assign dec_client = req_client;
  assign req_idx    = req_client[LANE_BITS +: IDX_BITS];   // high bits pick the entry

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= LANE_IDLE;
    end else begin
      case (state)
        LANE_IDLE:   if (cmd_valid) state <= LANE_READ;
        LANE_READ:   state <= LANE_UPDATE;
        LANE_UPDATE: state <= (req_op == OP_ORDER) ? LANE_POST : LANE_IDLE;
        LANE_POST:   if (dec_ready) state <= LANE_IDLE;   // hold until collector takes it
        default:     state <= LANE_IDLE;
      endcase
    end
  end

  // capture command on handshake
  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      req_op     <= cmd_op;
      req_client <= cmd_client;
      req_amount <= cmd_amount;
    end
  end

  // cycle 1, table read
  always_ff @(posedge clk) begin
    if (state == LANE_READ) begin
      cur_max <= max_tab[req_idx];
      cur_acc <= acc_tab[req_idx];
    end
  end

  // risk rules
  always_comb begin
    sum     = exposure_t'(cur_acc) + exposure_t'(req_amount);   // 17 bits, no wrap
    accept  = 1'b0;
    new_max = cur_max;
    new_acc = cur_acc;
    case (req_op)
      OP_ORDER: begin
        accept = (sum < exposure_t'(cur_max));   // strictly below the max
        if (accept) begin
          new_acc = amount_t'(sum);              // fits, sum < max
        end
      end
      OP_SET_MAX: new_max = req_amount;
      OP_CANCEL: begin
        // saturate at zero
        if (req_amount >= cur_acc) new_acc = '0;
        else                       new_acc = cur_acc - req_amount;
      end
      default: ;
    endcase
  end

  // cycle 2, write back; all limits start at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ENTRIES; i++) begin
        max_tab[i] <= '0;
        acc_tab[i] <= '0;
      end
    end else if (state == LANE_UPDATE) begin
      max_tab[req_idx] <= new_max;
      acc_tab[req_idx] <= new_acc;
    end
  end

  // decision payload for the post cycle
  always_ff @(posedge clk) begin
    if (state == LANE_UPDATE) begin
      dec_accept <= accept;
      dec_acc    <= new_acc;   // acc after the order, unchanged on reject
    end
  end

endmodule

// ==== src/order_dispatch.sv ====
`timescale 1ns/1ns

module order_dispatch import risk_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // wishbone classic slave
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  cmd_op_t              wb_adr,
  input  logic [31:0]          wb_dat_w,
  output logic                 wb_ack,
  output logic [31:0]          wb_dat_r,
  // command bus to the lanes
  output logic [NUM_LANES-1:0] cmd_valid,
  input  logic [NUM_LANES-1:0] cmd_ready,
  output cmd_op_t              cmd_op,
  output client_id_t           cmd_client,
  output amount_t              cmd_amount,
  // result fifo read side
  input  logic                 fifo_empty,
  input  decision_t            fifo_head,
  output logic                 fifo_pop
);

  localparam int LANE_BITS = $clog2(NUM_LANES);

  typedef logic [LANE_BITS-1:0] lane_idx_t;

  logic           wb_req;       // live bus cycle, not yet acked
  logic           is_cmd;       // write that goes to a lane
  logic           cmd_req;
  logic           cmd_fire;     // transfer to target lane this edge
  logic           rd_req;
  logic           ack_next;
  lane_idx_t      lane_sel;
  logic [NUM_LANES-1:0] lane_onehot;

  // ack blocks the request in its own cycle, so one transfer per bus cycle
  assign wb_req = wb_cyc & wb_stb & ~wb_ack;
  assign is_cmd = wb_we & (wb_adr != OP_DECISION);
  assign rd_req = wb_req & ~wb_we;

  // field decode straight from the write data
  assign cmd_op     = wb_adr;
  assign cmd_client = wb_dat_w[WR_CLIENT_LSB +: $bits(client_id_t)];
  assign cmd_amount = wb_dat_w[WR_AMOUNT_LSB +: $bits(amount_t)];

  // shard by the low client bits
  assign lane_sel    = cmd_client[LANE_BITS-1:0];
  assign lane_onehot = {{(NUM_LANES-1){1'b0}}, 1'b1} << lane_sel;

  assign cmd_req   = wb_req & is_cmd;
  assign cmd_valid = cmd_req ? lane_onehot : '0;   // held until the lane takes it
  assign cmd_fire  = cmd_req & cmd_ready[lane_sel];

  // pop only when there is something to hand back
  assign fifo_pop = rd_req & (wb_adr == OP_DECISION) & ~fifo_empty;

  // reads and writes to code 3 ack next cycle, commands wait for the lane
  assign ack_next = cmd_fire | (wb_req & ~is_cmd);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= ack_next;           // single cycle, wb_req drops while high
    end
  end

  // read data; head already carries the valid bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_dat_r <= '0;
    end else if (ack_next) begin
      if (fifo_pop) begin
        wb_dat_r <= fifo_head;
      end else begin
        wb_dat_r <= '0;             // writes, empty reads, codes 0..2
      end
    end
  end

endmodule

// ==== src/risk_pkg.sv ====
package risk_pkg;

  localparam int NUM_CLIENTS = 32;           // total client ids, shared by all lanes

  typedef logic [4:0]  client_id_t;          // client 0..31
  typedef logic [15:0] amount_t;             // order / limit / cancel amount
  typedef logic [16:0] exposure_t;           // acc + amount, one spare bit
  typedef logic [1:0]  cmd_op_t;             // command code, from wishbone adr

  // command codes
  localparam cmd_op_t OP_ORDER    = 2'd0;
  localparam cmd_op_t OP_SET_MAX  = 2'd1;
  localparam cmd_op_t OP_CANCEL   = 2'd2;
  localparam cmd_op_t OP_DECISION = 2'd3;    // read side only

  typedef logic [31:0] decision_t;

  // decision word layout
  localparam int DEC_ACCEPT_BIT = 31;
  localparam int DEC_VALID_BIT  = 30;
  localparam int DEC_CLIENT_LSB = 24;        // bits 28:24
  localparam int DEC_ACC_LSB    = 0;         // bits 15:0

  // write data layout on wb_dat_w
  localparam int WR_CLIENT_LSB = 16;         // bits 20:16
  localparam int WR_AMOUNT_LSB = 0;          // bits 15:0

  // lane fsm
  typedef enum logic [1:0] {
    LANE_IDLE,
    LANE_READ,
    LANE_UPDATE,
    LANE_POST
  } lane_state_t;

endpackage
